//--- delay_pipe.sv
// ------------------------------------------------------------
// Fixed-depth shift register for any payload type.
// q is d delayed by DEPTH clocks.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module delay_pipe #(
	parameter type data_t = logic [7:0],
	parameter int  DEPTH  = 15
) (
	input  wire   clk,
	input  data_t d,
	output data_t q
);

	data_t stage [DEPTH]; // no reset, pure data path

	always_ff @(posedge clk) begin
		stage[0] <= d;
		for (int i = 1; i < DEPTH; i++) begin
			stage[i] <= stage[i-1]; // shift every clock
		end
	end

	assign q = stage[DEPTH-1]; // oldest sample

endmodule

`default_nettype wire

//--- event_capture.sv
// ------------------------------------------------------------
// Event side of the readout. Encodes the 8-bit MCU trigger
// word, holds the last corrected energy and turns energy
// loads and spy triggers into a registered frame request.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module event_capture import trigger_readout_pkg::*; (
	input  wire       clk,
	input  wire       rst,
	input  wire       event_det,
	input  evtime_t   event_time,
	input  wire       enecor_load,
	input  energy_t   enecor,
	input  wire       trigger,
	output mcu_word_t mcu_trigger,
	output energy_t   energy,
	output logic      frame_start
);

	logic time_sat; // coarse time bits all ones

	assign time_sat = (event_time[11:6] == 6'h3F);

	// coincidence trigger word, one clock after the event
	always_ff @(posedge clk) begin
		if (rst) begin
			mcu_trigger <= MCU_IDLE_WORD;
		end else if (!event_det) begin
			mcu_trigger <= MCU_IDLE_WORD;   // nothing to report
		end else if (time_sat) begin
			mcu_trigger <= MCU_SAT_WORD;    // clamp late events
		end else begin
			mcu_trigger <= event_time[11:4]; // time in 1/16 clk units
		end
	end

	// energy held until the next load
	always_ff @(posedge clk) begin
		if (rst)
			energy <= '0;
		else if (enecor_load)
			energy <= enecor;
	end

	// load strobe or spy level both start a frame
	always_ff @(posedge clk) begin
		if (rst)
			frame_start <= 1'b0;
		else
			frame_start <= enecor_load | trigger;
	end

endmodule

`default_nettype wire

//--- flist.f
trigger_readout_pkg.sv
delay_pipe.sv
sample_window.sv
event_capture.sv
frame_writer.sv
sync_fifo.sv
trigger_readout_top.sv
tb_clkgen.sv
trigger_readout_chk.sv
tb_trigger_readout.sv

//--- frame_writer.sv
// ------------------------------------------------------------
// Framing FSM. On frame_start it writes preamble, word count,
// channel mask, N-1 sample words and the energy word into
// the FIFO on consecutive clocks, then idles at least once.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_writer import trigger_readout_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        frame_start,
	input  data_mode_t trigger_data_mode,
	input  wire  [1:0] trigger_channel_select,
	input  sample_t    sample_out,
	input  energy_t    energy,
	output logic       wr_en,
	output word_t      wr_data
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_PREAMBLE,
		S_NWORDS,
		S_MASK,
		S_DATA
	} state_t;

	state_t     state;
	logic [5:0] cnt;     // words left after the header
	word_t      n_words; // word count for this mode

	assign n_words = frame_words(trigger_data_mode);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			wr_en <= 1'b0;
			cnt   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					wr_en <= 1'b0;
					cnt   <= n_words[5:0];  // reload every idle clock
					if (frame_start)
						state <= S_PREAMBLE;
				end
				S_PREAMBLE: begin
					wr_en <= 1'b1;
					state <= S_NWORDS;
				end
				S_NWORDS: begin
					wr_en <= 1'b1;
					state <= S_MASK;
				end
				S_MASK: begin
					wr_en <= 1'b1;
					state <= S_DATA;
				end
				S_DATA: begin
					wr_en <= 1'b1;
					cnt   <= cnt - 6'd1;
					if (cnt == 6'd1)
						state <= S_IDLE;    // energy is the last word
				end
				default: begin
					wr_en <= 1'b0;
					state <= S_IDLE;
				end
			endcase
		end
	end

	// word written alongside wr_en
	always_ff @(posedge clk) begin
		case (state)
			S_PREAMBLE: wr_data <= PREAMBLE_WORD;
			S_NWORDS:   wr_data <= n_words;
			S_MASK:     wr_data <= chan_mask(trigger_channel_select);
			S_DATA: begin
				if (cnt == 6'd1)
					wr_data <= {4'b0000, energy};
				else
					wr_data <= {4'b0000, sample_out}; // delayed samples
			end
			default:    wr_data <= wr_data;
		endcase
	end

endmodule

`default_nettype wire

//--- sample_window.sv
// ------------------------------------------------------------
// Sample stream for the readout frames. Aligns raw and
// corrected samples, picks one by trigger_data_mode, then
// applies the pileup delay and a programmable tap.
// sample_out lags the input by 20 + data_pipeline_len clocks.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_window import trigger_readout_pkg::*; (
	input  wire        clk,
	input  adc_t       adc_raw,
	input  sample_t    adc_blcor,
	input  data_mode_t trigger_data_mode,
	input  wire  [3:0] data_pipeline_len,
	output sample_t    sample_out
);

	// last pileup stage doubles as first line stage
	localparam int LINE_OFS  = PILEUP_DLY - 1;
	localparam int CHAIN_LEN = LINE_OFS + 16;

	adc_t    raw_al;              // aligned raw sample
	sample_t blcor_al;            // aligned corrected sample
	sample_t sel;                 // selected stream
	sample_t chain [CHAIN_LEN];   // pileup stages then 16 deep line

	delay_pipe #(
		.data_t (adc_t),
		.DEPTH  (ALIGN_DLY)
	) u_raw_align (
		.clk (clk),
		.d   (adc_raw),
		.q   (raw_al)
	);

	delay_pipe #(
		.data_t (sample_t),
		.DEPTH  (ALIGN_DLY)
	) u_blcor_align (
		.clk (clk),
		.d   (adc_blcor),
		.q   (blcor_al)
	);

	always_ff @(posedge clk) begin
		if (trigger_data_mode == 2'd1)
			sel <= {4'b0000, raw_al}; // raw adc, upper bits zero
		else
			sel <= blcor_al;          // baseline corrected
	end

	always_ff @(posedge clk) begin
		chain[0] <= sel;
		for (int i = 1; i < CHAIN_LEN; i++) begin
			chain[i] <= chain[i-1];
		end
	end

	// tap register, 0 gives the shortest delay
	always_ff @(posedge clk) begin
		sample_out <= chain[LINE_OFS + int'(data_pipeline_len)];
	end

endmodule

`default_nettype wire

//--- sync_fifo.sv
// ------------------------------------------------------------
// Single-clock first-word-fallthrough FIFO. q shows the head
// word while nempty is high; ren pops it. Writes into a full
// FIFO are lost, nearly_full warns when a frame may not fit.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sync_fifo import trigger_readout_pkg::*; #(
	parameter int  DEPTH  = 64,
	parameter type data_t = word_t
) (
	input  wire   clk,
	input  wire   rst,
	input  wire   wr_en,
	input  data_t wr_data,
	input  wire   ren,
	output data_t q,
	output logic  nempty,
	output logic  nearly_full
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	data_t          mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [CW-1:0]  count;    // occupancy
	logic           do_wr;    // accepted write
	logic           do_rd;    // accepted read

	assign do_wr = wr_en && (count != CW'(DEPTH)); // drop when full
	assign do_rd = ren && nempty;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(do_wr) - CW'(do_rd);
		end
	end

	assign q           = mem[rd_ptr];  // fallthrough head word
	assign nempty      = (count != '0);
	assign nearly_full = (CW'(DEPTH) - count) < CW'(MAX_FRAME); // no room for a frame

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// ------------------------------------------------------------
// Testbench clock and reset source. clk runs at PERIOD ns,
// rst stays high for the first RST_CYCLES rising edges.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD     = 40,
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#2 rst = 1'b0; // released with the stimulus skew
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- tb_trigger_readout.sv
// ------------------------------------------------------------
// Testbench for the trigger readout. Drives sample ramps,
// random events and energy loads, drains the FIFO and parses
// every frame. The bound checker watches the DUT internals.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_trigger_readout import trigger_readout_pkg::*; ();

	localparam int FRAME_SUM  = 4 * (4 + 36 + 36 + 20) + 3 * 36 + 2 * 20; // all frame words
	localparam int TIMEOUT    = 4 * FRAME_SUM + 200;                    // in cycles
	localparam int FIFO_WORDS = 64;                                     // readout fifo depth

	logic        clk;
	logic        rst;
	logic        event_det              = 1'b0;
	evtime_t     event_time             = '0;
	adc_t        adc_raw;
	sample_t     adc_blcor              = '0;   // ramp, one step per clock
	logic        enecor_load            = 1'b0;
	energy_t     enecor                 = '0;
	logic        trigger                = 1'b0;
	data_mode_t  trigger_data_mode      = 2'd0;
	logic [3:0]  data_pipeline_len      = 4'd0;
	logic [1:0]  trigger_channel_select = 2'd0;
	mcu_word_t   mcu_trigger;
	logic        fifo_ren               = 1'b0;
	word_t       fifo_q;
	logic        fifo_ne;
	logic        fifo_full;
	logic        read_en                = 1'b1; // drain enable
	logic [15:0] lfsr                   = 16'd20;
	energy_t     last_energy            = '0;
	int          errors                 = 0;
	int          cycles                 = 0;
	word_t       rx_q [$];                      // words popped so far
	logic        full_log [$];                  // fifo_full seen with each pop

	assign adc_raw = adc_blcor[7:0]; // raw ramp is the low byte

	tb_clkgen #(.PERIOD(40), .RST_CYCLES(3)) u_clkgen (.*);
	trigger_readout_top #(.FIFO_DEPTH(FIFO_WORDS)) u_trigger_readout_top (.*);

	always @(posedge clk) begin
		#2;
		adc_blcor = adc_blcor + 12'd1;
		fifo_ren  = read_en && fifo_ne; // pop whenever a word waits
	end

	always @(negedge clk) begin
		if (fifo_ren) begin
			full_log.push_back(fifo_full); // level while this word is still stored
			rx_q.push_back(fifo_q); // head word, popped at the next edge
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
			finish_run(1'b1);
		end
	end

	task automatic finish_run(input logic timed_out);
		int chk_fails;
		chk_fails = u_trigger_readout_top.u_chk.fail_count;
		$display("errors: %0d frame checks failed, %0d assertions failed", errors, chk_fails);
		if (errors == 0 && chk_fails == 0 && !timed_out)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic expect_word(input string name, input word_t got, input word_t exp);
		assert (got === exp)
		else begin
			errors++;
			$display("CHECK FAILED %s got %h exp %h", name, got, exp);
		end
	endtask

	// fibonacci lfsr x^16+x^14+x^13+x^11+1
	function automatic logic [23:0] rand_bits(input int n);
		logic [23:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v    = {v[22:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int exp_count(input data_mode_t mode);
		case (mode)
			2'd0:    return 1;  // energy only
			2'd3:    return 17;
			default: return 33;
		endcase
	endfunction

	task automatic load_energy(output logic [11:0] ramp_at);
		step_cycle();
		enecor      = energy_t'(rand_bits(12));
		enecor_load = 1'b1;
		last_energy = enecor;
		@(negedge clk);
		ramp_at     = adc_blcor; // ramp seen with the strobe
		step_cycle();
		enecor_load = 1'b0;
	endtask

	task automatic check_frame(input data_mode_t mode, input logic [1:0] sel,
		input energy_t eng, output logic [11:0] first);
		int    n;
		word_t w;
		word_t prev;
		word_t hi_mask;
		n       = exp_count(mode);
		hi_mask = (mode == 2'd1) ? 16'hFF00 : 16'hF000; // raw samples are 8 bits
		first   = '0;
		while (rx_q.size() < HDR_WORDS + n) @(negedge clk);
		expect_word("preamble", rx_q.pop_front(), PREAMBLE_WORD);
		expect_word("word_count", rx_q.pop_front(), word_t'(n));
		expect_word("chan_mask", rx_q.pop_front(), word_t'(16'h0001 << sel));
		for (int i = 0; i < n - 1; i++) begin
			w = rx_q.pop_front();
			expect_word("sample_upper", w & hi_mask, 16'h0000);
			if (i == 0)
				first = w[11:0];
			else
				expect_word("sample_step", w & ~hi_mask, (prev + 16'd1) & ~hi_mask);
			prev = w;
		end
		expect_word("energy", rx_q.pop_front(), {4'h0, eng}); // last word of the frame
	endtask

	initial begin
		logic [11:0] ramp_at;
		logic [11:0] first;
		logic [11:0] ofs_ref;
		int          n_stored;
		@(negedge clk);
		while (rst) @(negedge clk);
		repeat (5) step_cycle(); // idle trigger word before any event
		for (int i = 0; i < 40; i++) begin
			step_cycle();
			event_det  = 1'(rand_bits(1));
			event_time = rand_bits(24);
			if (i % 4 == 3)
				event_time[11:6] = 6'h3F; // force saturation
		end
		step_cycle();
		event_det = 1'b0;
		for (int m = 0; m < 4; m++) begin
			trigger_data_mode = data_mode_t'(m);
			repeat (48) step_cycle(); // flush the sample pipeline
			for (int s = 0; s < 4; s++) begin
				trigger_channel_select = 2'(s);
				load_energy(ramp_at);
				check_frame(trigger_data_mode, trigger_channel_select, last_energy, first);
			end
		end
		trigger_data_mode      = 2'd2;
		trigger_channel_select = 2'd0;
		for (int k = 0; k < 3; k++) begin
			data_pipeline_len = 4'(k * 7); // taps 0, 7, 14
			repeat (48) step_cycle();
			load_energy(ramp_at);
			check_frame(2'd2, 2'd0, last_energy, first);
			if (k == 0)
				ofs_ref = ramp_at - first; // latency at tap 0
			else
				expect_word("tap_shift", 16'(12'(ramp_at - first - ofs_ref)), 16'(k * 7));
		end
		trigger_data_mode = 2'd3;
		repeat (48) step_cycle();
		@(negedge clk);
		read_en = 1'b0; // let spy frames pile up
		step_cycle();
		trigger = 1'b1;
		while (!fifo_full) @(negedge clk);
		step_cycle();
		trigger = 1'b0;
		repeat (30) step_cycle(); // open frame finishes
		@(negedge clk);
		read_en = 1'b1;
		full_log.delete(); // occupancy only falls from here on
		repeat (3) step_cycle();
		while (fifo_ne) @(negedge clk);
		n_stored = rx_q.size();
		foreach (full_log[j])
			expect_word("fifo_full", 16'(full_log[j]),
				16'((FIFO_WORDS - (n_stored - j)) < MAX_FRAME)); // fewer free than a frame
		while (rx_q.size() >= HDR_WORDS + exp_count(2'd3))
			check_frame(2'd3, 2'd0, last_energy, first);
		repeat (10) step_cycle();
		expect_word("rx_leftover", 16'(rx_q.size()), 16'h0000);
		finish_run(1'b0);
	end

endmodule

`default_nettype wire

//--- trigger_readout_chk.sv
// ------------------------------------------------------------
// Bound checker for trigger_readout_top. Watches the MCU
// trigger word, the header order on the FIFO write side
// and the FIFO and trigger word state after reset.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module trigger_readout_chk import trigger_readout_pkg::*; (
	input wire        clk,
	input wire        rst,
	input wire        event_det,
	input evtime_t    event_time,
	input mcu_word_t  mcu_trigger,
	input wire        fifo_ne,
	input wire        wr_en,
	input word_t      wr_data,
	input data_mode_t trigger_data_mode,
	input wire  [1:0] trigger_channel_select
);

	int        fail_count = 0; // failed assertions so far
	logic      rst_d;          // reset one clock ago
	mcu_word_t mcu_exp;        // word due one clock after the inputs
	logic      pre_d1;         // preamble written last clock
	logic      pre_d2;         // preamble written two clocks ago
	word_t     count_exp;
	word_t     mask_exp;

	assign count_exp = (trigger_data_mode == 2'd0) ? 16'd1 :
		(trigger_data_mode == 2'd3) ? 16'd17 : 16'd33;
	assign mask_exp  = word_t'(16'h0001 << trigger_channel_select); // one-hot channel

	always_ff @(posedge clk) begin
		rst_d <= rst;
		if (!event_det)
			mcu_exp <= 8'hFF;             // no event
		else if (event_time[11:6] == 6'h3F)
			mcu_exp <= 8'hF8;             // time saturated
		else
			mcu_exp <= event_time[11:4];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pre_d1 <= 1'b0;
			pre_d2 <= 1'b0;
		end else begin
			pre_d1 <= wr_en && (wr_data == PREAMBLE_WORD); // data words never reach A5A5
			pre_d2 <= pre_d1;
		end
	end

	a_mcu_word: assert property (@(posedge clk) disable iff (rst) !rst_d |-> mcu_trigger == mcu_exp)
		else begin
			$error("CHECK FAILED mcu_trigger got %h exp %h", $sampled(mcu_trigger), $sampled(mcu_exp));
			fail_count++;
		end

	a_word_count: assert property (@(posedge clk) disable iff (rst)
		pre_d1 |-> wr_en && wr_data == count_exp)
		else begin
			$error("CHECK FAILED wr_data count got %h exp %h", $sampled(wr_data), $sampled(count_exp));
			fail_count++;
		end

	a_chan_mask: assert property (@(posedge clk) disable iff (rst)
		pre_d2 |-> wr_en && wr_data == mask_exp)
		else begin
			$error("CHECK FAILED wr_data mask got %h exp %h", $sampled(wr_data), $sampled(mask_exp));
			fail_count++;
		end

	a_after_rst: assert property (@(posedge clk) rst |=> !fifo_ne && mcu_trigger == MCU_IDLE_WORD)
		else begin
			$error("CHECK FAILED after reset fifo_ne %h mcu_trigger %h exp 0 ff",
				$sampled(fifo_ne), $sampled(mcu_trigger));
			fail_count++;
		end

endmodule

bind trigger_readout_top trigger_readout_chk u_chk (.*);

`default_nettype wire

//--- trigger_readout_pkg.sv
// ------------------------------------------------------------
// Shared types, constants and frame rules for the dynode
// trigger readout path. Imported by the RTL and testbench.
// ------------------------------------------------------------
`default_nettype none

package trigger_readout_pkg;

	typedef logic [7:0]  adc_t;       // raw dynode adc sample
	typedef logic [11:0] sample_t;    // corrected or zero-extended raw sample
	typedef logic [15:0] word_t;      // one fifo word
	typedef logic [23:0] evtime_t;    // event start time
	typedef logic [11:0] energy_t;    // corrected integrated energy
	typedef logic [1:0]  data_mode_t; // 1 = raw adc, else corrected
	typedef logic [7:0]  mcu_word_t;  // coincidence trigger word

	localparam word_t     PREAMBLE_WORD = 16'hA5A5; // first word of a frame
	localparam int        HDR_WORDS     = 3;        // preamble, count, mask
	localparam mcu_word_t MCU_IDLE_WORD = 8'hFF;    // no event this cycle
	localparam mcu_word_t MCU_SAT_WORD  = 8'hF8;    // event time saturated
	localparam int        PILEUP_DLY    = 3;        // extra sample delay
	localparam int        ALIGN_DLY     = 15;       // both sample streams
	localparam int        MAX_FRAME     = 36;       // longest frame in words

	// words following the header, energy word included
	function automatic word_t frame_words(input data_mode_t mode);
		case (mode)
			2'd0:    return 16'd1;  // energy only
			2'd1:    return 16'd33; // 32 raw samples + energy
			2'd2:    return 16'd33; // 32 corrected samples + energy
			default: return 16'd17; // 16 corrected samples + energy
		endcase
	endfunction

	// one-hot channel mask for the header
	function automatic word_t chan_mask(input logic [1:0] sel);
		return word_t'(16'h0001 << sel);
	endfunction

endpackage

`default_nettype wire

//--- trigger_readout_top.sv
// ------------------------------------------------------------
// Top of the dynode trigger readout. Ties the sample window,
// event capture, frame writer and readout FIFO together.
// The FIFO is drained through fifo_ren / fifo_q / fifo_ne.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module trigger_readout_top import trigger_readout_pkg::*; #(
	parameter int FIFO_DEPTH = 64
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        event_det,
	input  evtime_t    event_time,
	input  adc_t       adc_raw,
	input  sample_t    adc_blcor,
	input  wire        enecor_load,
	input  energy_t    enecor,
	input  wire        trigger,
	input  data_mode_t trigger_data_mode,
	input  wire  [3:0] data_pipeline_len,
	input  wire  [1:0] trigger_channel_select,
	output mcu_word_t  mcu_trigger,
	input  wire        fifo_ren,
	output word_t      fifo_q,
	output wire        fifo_ne,
	output wire        fifo_full
);

	sample_t sample_out;  // delayed sample for frame data
	energy_t energy;      // last corrected energy
	wire     frame_start; // registered frame request
	wire     wr_en;
	word_t   wr_data;

	sample_window u_sample_window (
		.clk               (clk),
		.adc_raw           (adc_raw),
		.adc_blcor         (adc_blcor),
		.trigger_data_mode (trigger_data_mode),
		.data_pipeline_len (data_pipeline_len),
		.sample_out        (sample_out)
	);

	event_capture u_event_capture (
		.clk         (clk),
		.rst         (rst),
		.event_det   (event_det),
		.event_time  (event_time),
		.enecor_load (enecor_load),
		.enecor      (enecor),
		.trigger     (trigger),
		.mcu_trigger (mcu_trigger),
		.energy      (energy),
		.frame_start (frame_start)
	);

	frame_writer u_frame_writer (
		.clk                    (clk),
		.rst                    (rst),
		.frame_start            (frame_start),
		.trigger_data_mode      (trigger_data_mode),
		.trigger_channel_select (trigger_channel_select),
		.sample_out             (sample_out),
		.energy                 (energy),
		.wr_en                  (wr_en),
		.wr_data                (wr_data)
	);

	sync_fifo #(
		.DEPTH  (FIFO_DEPTH),
		.data_t (word_t)
	) u_sync_fifo (
		.clk         (clk),
		.rst         (rst),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.ren         (fifo_ren),
		.q           (fifo_q),
		.nempty      (fifo_ne),
		.nearly_full (fifo_full)
	);

endmodule

`default_nettype wire
